//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_device_handler
FILELIST  := device_handler.f
OBJ_DIR   := obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf $(OBJ_DIR)

//--- device_handler.f
hdl/io_pkg.sv
hdl/spi_frame_receiver.sv
hdl/command_fsm.sv
hdl/phase_accumulator.sv
hdl/wave_table.sv
hdl/pin_driver.sv
hdl/device_handler.sv
sim/tb_device_handler.sv

//--- hdl/command_fsm.sv
module command_fsm
    import io_pkg::*;
#(
    parameter int IO_BITS = 10
) (
    input  logic               clk,
    input  logic               nreset,
    input  frame_t             frame,
    input  logic               frame_done,
    output logic               mode_we,
    output mode_t              mode_value,
    output logic               table_we,
    output wave_addr_t         table_addr,
    output logic [IO_BITS-1:0] table_data,
    output logic               tune_we,
    output phase_t             tune_word
);
    typedef enum logic {
        IDLE,
        EXEC
    } state_t;

    state_t     state;
    frame_t     cmd;
    device_id_t device_id;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (frame_done) state <= EXEC;
                EXEC: state <= IDLE; // Every command completes in one cycle
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && frame_done) begin
            cmd <= frame;
        end
    end

    assign device_id  = cmd[3:0];
    assign mode_value = cmd[7:4];
    assign table_addr = cmd[11:4];
    assign table_data = cmd[IO_BITS+11:12];
    assign tune_word  = cmd[35:4];

    always_comb begin
        mode_we  = 1'b0;
        table_we = 1'b0;
        tune_we  = 1'b0;
        if (state == EXEC) begin
            case (device_id)
                DEV_MODE:  mode_we = 1'b1;
                DEV_TABLE: table_we = 1'b1;
                DEV_TUNE:  tune_we = 1'b1;
                default: ; // Unknown ids are dropped
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!nreset)
        $onehot0({mode_we, table_we, tune_we}));

endmodule

//--- hdl/device_handler.sv
module device_handler
    import io_pkg::*;
#(
    parameter int SPI_BITS = 3,
    parameter int IO_BITS  = 10
) (
    input  logic                clk,
    input  logic                nreset,
    input  logic [SPI_BITS-1:0] sdi,
    input  logic                sclk,
    input  logic                sncs,
    input  logic [IO_BITS-1:0]  module_in, // Not read while the pins carry the DDS waveform
    output logic [IO_BITS-1:0]  module_out,
    output logic [IO_BITS-1:0]  module_oe
);
    frame_t             frame;
    logic               frame_done;
    logic               mode_we;
    mode_t              mode_value;
    logic               table_we;
    wave_addr_t         table_addr;
    logic [IO_BITS-1:0] table_data;
    logic               tune_we;
    phase_t             tune_word;
    wave_addr_t         read_addr;
    logic [IO_BITS-1:0] sample;

    spi_frame_receiver #(.SPI_BITS(SPI_BITS)) u_receiver (
        .clk        (clk),
        .nreset     (nreset),
        .sclk       (sclk),
        .sncs       (sncs),
        .sdi        (sdi),
        .frame      (frame),
        .frame_done (frame_done)
    );

    command_fsm #(.IO_BITS(IO_BITS)) u_fsm (
        .clk        (clk),
        .nreset     (nreset),
        .frame      (frame),
        .frame_done (frame_done),
        .mode_we    (mode_we),
        .mode_value (mode_value),
        .table_we   (table_we),
        .table_addr (table_addr),
        .table_data (table_data),
        .tune_we    (tune_we),
        .tune_word  (tune_word)
    );

    phase_accumulator u_phase (
        .clk       (clk),
        .nreset    (nreset),
        .tune_we   (tune_we),
        .tune_word (tune_word),
        .read_addr (read_addr)
    );

    wave_table #(.IO_BITS(IO_BITS)) u_table (
        .clk        (clk),
        .table_we   (table_we),
        .table_addr (table_addr),
        .table_data (table_data),
        .read_addr  (read_addr),
        .sample     (sample)
    );

    pin_driver #(.IO_BITS(IO_BITS)) u_pins (
        .clk        (clk),
        .nreset     (nreset),
        .mode_we    (mode_we),
        .mode_value (mode_value),
        .sample     (sample),
        .module_out (module_out),
        .module_oe  (module_oe)
    );

endmodule

//--- hdl/io_pkg.sv
package io_pkg;

    localparam int FRAME_BITS = 36;

    typedef logic [FRAME_BITS-1:0] frame_t;
    typedef logic [3:0]            device_id_t; // Frame bits 3 to 0
    typedef logic [3:0]            mode_t;      // Frame bits 7 to 4
    typedef logic [31:0]           phase_t;
    typedef logic [7:0]            wave_addr_t;

    // Output modes
    localparam mode_t MODE_NONE = 4'h0;
    localparam mode_t MODE_DDS  = 4'h1;

    // Command selectors in the low nibble of a frame
    localparam device_id_t DEV_MODE  = 4'h0;
    localparam device_id_t DEV_TABLE = 4'h1;
    localparam device_id_t DEV_TUNE  = 4'h2;

endpackage

//--- hdl/phase_accumulator.sv
module phase_accumulator
    import io_pkg::*;
(
    input  logic       clk,
    input  logic       nreset,
    input  logic       tune_we,
    input  phase_t     tune_word,
    output wave_addr_t read_addr
);
    phase_t tune;
    phase_t phase;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            tune  <= '0;
            phase <= '0;
        end else begin
            if (tune_we) begin
                tune <= tune_word;
            end
            phase <= phase + tune; // Wraps modulo 2**32
        end
    end

    // Top byte indexes the waveform table
    assign read_addr = phase[31:24];

endmodule

//--- hdl/pin_driver.sv
module pin_driver
    import io_pkg::*;
#(
    parameter int IO_BITS = 10
) (
    input  logic               clk,
    input  logic               nreset,
    input  logic               mode_we,
    input  mode_t              mode_value,
    input  logic [IO_BITS-1:0] sample,
    output logic [IO_BITS-1:0] module_out,
    output logic [IO_BITS-1:0] module_oe
);
    mode_t mode;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            mode       <= MODE_NONE;
            module_out <= '0;
            module_oe  <= '0;
        end else begin
            if (mode_we) begin
                mode <= mode_value;
            end
            if (mode == MODE_DDS) begin
                module_out <= sample;
                module_oe  <= '1;
            end else begin
                module_out <= '0; // Pins released in any other mode
                module_oe  <= '0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!nreset)
        (module_oe == '0) |-> (module_out == '0));

endmodule

//--- hdl/spi_frame_receiver.sv
module spi_frame_receiver
    import io_pkg::*;
#(
    parameter int SPI_BITS = 3
) (
    input  logic                clk,
    input  logic                nreset,
    input  logic                sclk,
    input  logic                sncs,
    input  logic [SPI_BITS-1:0] sdi,
    output frame_t              frame,
    output logic                frame_done
);
    logic [1:0]          sclk_sync;
    logic [1:0]          sncs_sync;
    logic [SPI_BITS-1:0] sdi_meta;
    logic [SPI_BITS-1:0] sdi_sync;
    logic                sclk_prev;
    logic                sncs_prev;
    logic                sclk_rise;
    logic                sncs_rise;

    assign sclk_rise = sclk_sync[1] && !sclk_prev;
    assign sncs_rise = sncs_sync[1] && !sncs_prev;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            sclk_sync  <= 2'b00;
            sncs_sync  <= 2'b11; // Chip select idles high
            sclk_prev  <= 1'b0;
            sncs_prev  <= 1'b1;
            frame_done <= 1'b0;
        end else begin
            sclk_sync  <= {sclk_sync[0], sclk};
            sncs_sync  <= {sncs_sync[0], sncs};
            sclk_prev  <= sclk_sync[1];
            sncs_prev  <= sncs_sync[1];
            frame_done <= sncs_rise;
        end
    end

    // Data lanes take the same two flop path as sclk so they stay aligned with its edge
    always_ff @(posedge clk) begin
        sdi_meta <= sdi;
        sdi_sync <= sdi_meta;
        if (sclk_rise && !sncs_sync[1]) begin
            frame <= {frame[FRAME_BITS-SPI_BITS-1:0], sdi_sync};
        end
    end

    // The host keeps sncs high at least until the end of frame is seen
    assert property (@(posedge clk) disable iff (!nreset) frame_done |-> sncs_sync[1]);

endmodule

//--- hdl/wave_table.sv
module wave_table
    import io_pkg::*;
#(
    parameter int IO_BITS = 10
) (
    input  logic               clk,
    input  logic               table_we,
    input  wave_addr_t         table_addr,
    input  logic [IO_BITS-1:0] table_data,
    input  wave_addr_t         read_addr,
    output logic [IO_BITS-1:0] sample
);
    logic [IO_BITS-1:0] mem [0:255];

    // Same address on both ports gives the previous contents
    always_ff @(posedge clk) begin
        if (table_we) begin
            mem[table_addr] <= table_data;
        end
        sample <= mem[read_addr];
    end

endmodule

//--- sim/tb_device_handler.sv
module tb_device_handler
    import io_pkg::*;
();
    localparam int SPI_BITS = 3;
    localparam int IO_BITS  = 10;
    localparam int HOLD     = 5;   // Clocks per sclk level
    localparam int MARGIN   = 20;
    localparam int RUN      = 300; // Longer than one full sweep of the table at step 1
    localparam int FRAME_CLOCKS = 5 + 2 * HOLD * (FRAME_BITS / SPI_BITS) + 2 * HOLD;
    localparam int NUM_FRAMES   = 256 + 10;
    localparam int TIMEOUT_CLOCKS = 2 * (NUM_FRAMES * (FRAME_CLOCKS + MARGIN) + 10 * RUN);

    logic                clk;
    logic                nreset;
    logic [SPI_BITS-1:0] sdi;
    logic                sclk;
    logic                sncs;
    logic [IO_BITS-1:0]  module_in;
    logic [IO_BITS-1:0]  module_out;
    logic [IO_BITS-1:0]  module_oe;

    logic [IO_BITS-1:0] model_table [0:255];
    mode_t              model_mode;
    phase_t             model_tune;
    logic               used [0:2**IO_BITS-1];
    logic               check_en;
    logic               rewrite_seen;
    int                 rewrite_addr;
    int                 errors;
    int                 checks;
    int                 seed;

    device_handler #(.SPI_BITS(SPI_BITS), .IO_BITS(IO_BITS)) dut (
        .clk        (clk),
        .nreset     (nreset),
        .sdi        (sdi),
        .sclk       (sclk),
        .sncs       (sncs),
        .module_in  (module_in),
        .module_out (module_out),
        .module_oe  (module_oe)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Low nibble selects the device, the payload fills the upper 32 bits
    function automatic frame_t make_frame(input device_id_t id, input phase_t payload);
        return {payload, id};
    endfunction

    // Expected state of the handler after a frame has been executed
    function automatic void apply_frame(input frame_t f);
        case (f[3:0])
            DEV_MODE:  model_mode = f[7:4];
            DEV_TABLE: model_table[f[11:4]] = f[IO_BITS+11:12];
            DEV_TUNE:  model_tune = f[35:4];
            default: ;
        endcase
    endfunction

    function automatic int find_index(input logic [IO_BITS-1:0] value);
        for (int i = 0; i < 256; i++) begin
            if (model_table[i] === value) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Draws a table value that no other entry holds yet
    function automatic logic [IO_BITS-1:0] fresh_value();
        logic [31:0] draw;
        draw = $random(seed);
        while (used[draw[IO_BITS-1:0]]) begin
            draw = $random(seed);
        end
        used[draw[IO_BITS-1:0]] = 1'b1;
        return draw[IO_BITS-1:0];
    endfunction

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic send_frame(input frame_t f);
        sncs <= 1'b0;
        wait_clocks(5);
        for (int i = FRAME_BITS / SPI_BITS - 1; i >= 0; i--) begin
            sdi  <= f[i*SPI_BITS +: SPI_BITS]; // MSB lanes first
            sclk <= 1'b0;
            wait_clocks(HOLD);
            sclk <= 1'b1;
            wait_clocks(HOLD);
        end
        sclk <= 1'b0;
        wait_clocks(HOLD);
        sncs <= 1'b1; // Rising chip select executes the frame
        wait_clocks(HOLD);
    endtask

    task automatic pause_checks();
        check_en <= 1'b0;
        @(posedge clk);
    endtask

    // Outputs are not compared while a frame is sent and the change settles
    task automatic send_command(input frame_t f);
        pause_checks();
        apply_frame(f);
        send_frame(f);
        wait_clocks(MARGIN);
        check_en <= 1'b1;
    endtask

    always @(posedge clk) begin : compare
        int idx;
        int prev_idx;
        int expected;
        logic have_prev;
        if (!check_en) begin
            have_prev = 1'b0;
        end else if (model_mode == MODE_DDS) begin
            checks = checks + 1;
            idx = find_index(module_out);
            assert (module_oe == '1) else begin
                $display("Fail %0t: module_oe %h in DDS mode", $time, module_oe);
                errors = errors + 1;
            end
            assert (idx >= 0) else begin
                $display("Fail %0t: module_out %h is not in the table", $time, module_out);
                errors = errors + 1;
            end
            if (have_prev && idx >= 0) begin
                expected = (prev_idx + int'(model_tune[31:24])) % 256;
                assert (idx == expected) else begin
                    $display("Fail %0t: table index %0d, expected %0d", $time, idx, expected);
                    errors = errors + 1;
                end
            end
            if (idx == rewrite_addr) begin
                rewrite_seen = 1'b1;
            end
            have_prev = (idx >= 0);
            prev_idx  = idx;
        end else begin
            checks = checks + 1;
            assert (module_out == '0 && module_oe == '0) else begin
                $display("Fail %0t: pins %h oe %h while released", $time, module_out, module_oe);
                errors = errors + 1;
            end
        end
    end

    initial begin
        frame_t f;
        logic [31:0] draw;
        nreset = 1'b0;
        sclk = 1'b0;
        sncs = 1'b1;
        sdi = '0;
        module_in = '0;
        check_en = 1'b0;
        rewrite_seen = 1'b0;
        rewrite_addr = -1;
        errors = 0;
        checks = 0;
        seed = 32'h5c2f6ef5;
        model_mode = MODE_NONE;
        model_tune = '0;
        for (int i = 0; i < 2**IO_BITS; i++) begin
            used[i] = 1'b0;
        end
        wait_clocks(10);
        nreset <= 1'b1;
        @(posedge clk);
        check_en <= 1'b1;
        wait_clocks(50);

        // Pins stay released while the table is loaded
        for (int i = 0; i < 256; i++) begin
            f = make_frame(DEV_TABLE, 32'({fresh_value(), 8'(i)}));
            apply_frame(f);
            send_frame(f);
        end
        send_command(make_frame(DEV_TUNE, 32'h0100_0000));
        send_command(make_frame(DEV_MODE, 32'(MODE_DDS)));
        wait_clocks(RUN);
        send_command(make_frame(DEV_TUNE, 32'h0200_0000));
        wait_clocks(RUN);
        send_command(make_frame(DEV_TUNE, 32'h0000_0000));
        wait_clocks(RUN);

        // Unknown device id, compared all the way through
        draw = $random(seed);
        f = make_frame(4'h7, draw);
        apply_frame(f);
        send_frame(f);
        wait_clocks(MARGIN + RUN);

        send_command(make_frame(DEV_TUNE, 32'h0100_0000));
        pause_checks();
        draw = $random(seed);
        rewrite_addr = int'(draw[7:0]);
        rewrite_seen = 1'b0;
        send_command(make_frame(DEV_TABLE, 32'({fresh_value(), draw[7:0]})));
        wait_clocks(RUN);
        pause_checks();
        assert (rewrite_seen) else begin
            $display("The rewritten table entry %0d never reached module_out", rewrite_addr);
            errors = errors + 1;
        end

        send_command(make_frame(DEV_MODE, 32'(MODE_NONE)));
        wait_clocks(RUN);
        pause_checks();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait_clocks(TIMEOUT_CLOCKS);
        $display("Timeout after %0d clocks, the test sequence did not finish", TIMEOUT_CLOCKS);
        $display("Simulation failed");
        $finish;
    end

endmodule
